// File: hw/rst_mgr_pkg.sv
package rst_mgr_pkg;

	// Timing constants in CLK100KHZ cycles, kept short for simulation
	localparam int TMR_W          = 8;  // Delay and timeout counter width
	localparam int STRT_DLY       = 16; // Lock to system reset release
	localparam int ADC_RST_LEN    = 4;
	localparam int ADC_INIT_TMO   = 64; // Max wait for ADC init done
	localparam int FIFO_RST_LEN   = 8;
	localparam int TDIS_PULSE_LEN = 20;

	typedef enum logic [2:0] {
		ST_WAIT_LOCK,
		ST_STRT_DLY,
		ST_ADC_INIT,
		ST_AUTOLOAD,
		ST_AL_RELEASE,
		ST_RUN
	} por_state_e;

	// Asynchronous status inputs, synced as one word
	typedef struct packed {
		logic clk_lock;      // Clock manager locked
		logic adc_init_done;
		logic al_done;       // Auto-load acknowledge
		logic resync;
		logic daq_op_rst;
		logic trg_op_rst;
		logic restart;       // Request to rerun the power-on sequence
	} status_t;

	typedef struct packed {
		logic daq;
		logic trg;
	} link_tdis_t;

endpackage

// File: hw/status_sync.sv
`timescale 1ns/1ps

module status_sync import rst_mgr_pkg::*; (
	input  logic    CLK100KHZ,
	input  logic    EOS,
	input  status_t status_i,
	output status_t status_o
);

	status_t meta_q; // First stage, may go metastable

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			meta_q   <= '0;
			status_o <= '0;
		end else begin
			meta_q   <= status_i;
			status_o <= meta_q;
		end
	end

	// Whole word arrives two cycles later once both stages are out of reset
	a_two_cycle: assert property (
		@(posedge CLK100KHZ) disable iff (!EOS)
		$past(EOS, 1) && $past(EOS, 2) |-> status_o == $past(status_i, 2)
	) else $error("status_sync output is not the input delayed by two cycles");

endmodule

// File: hw/por_sequencer.sv
`timescale 1ns/1ps

module por_sequencer import rst_mgr_pkg::*; (
	input  logic       CLK100KHZ,
	input  logic       EOS,
	input  status_t    sync_status_i,
	input  logic       adc_rdy_i,
	output logic       sys_rst_o,
	output logic       adc_init_rst_o,
	output logic       al_start_o,
	output logic       run_o,
	output por_state_e por_state_o
);

	por_state_e       state;
	por_state_e       state_nxt;
	logic [TMR_W-1:0] dly_cnt;
	logic             abort;

	assign abort = sync_status_i.restart | ~sync_status_i.clk_lock;

	always_comb begin
		state_nxt = state;
		if (state != ST_WAIT_LOCK && abort) begin
			state_nxt = ST_WAIT_LOCK; // Restart or lost lock
		end else begin
			case (state)
				ST_WAIT_LOCK: begin
					if (sync_status_i.clk_lock && !sync_status_i.restart) begin
						state_nxt = ST_STRT_DLY;
					end
				end
				ST_STRT_DLY: begin
					if (dly_cnt == TMR_W'(STRT_DLY - 1)) begin
						state_nxt = ST_ADC_INIT;
					end
				end
				ST_ADC_INIT: begin
					if (adc_rdy_i) begin
						state_nxt = ST_AUTOLOAD;
					end
				end
				ST_AUTOLOAD: begin
					if (sync_status_i.al_done) begin
						state_nxt = ST_AL_RELEASE;
					end
				end
				ST_AL_RELEASE: begin
					if (!sync_status_i.al_done) begin
						state_nxt = ST_RUN; // Handshake fully closed
					end
				end
				ST_RUN: begin
					state_nxt = ST_RUN;
				end
				default: begin
					state_nxt = ST_WAIT_LOCK;
				end
			endcase
		end
	end

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			state   <= ST_WAIT_LOCK;
			dly_cnt <= '0;
		end else begin
			state   <= state_nxt;
			dly_cnt <= (state == ST_STRT_DLY) ? dly_cnt + 1'b1 : '0;
		end
	end

	assign sys_rst_o      = (state == ST_WAIT_LOCK) || (state == ST_STRT_DLY);
	assign adc_init_rst_o = sys_rst_o; // ADC init held off with the system
	assign al_start_o     = (state == ST_AUTOLOAD);
	assign run_o          = (state == ST_RUN);
	assign por_state_o    = state;

	a_run_al_excl: assert property (
		@(posedge CLK100KHZ) disable iff (!EOS)
		!(run_o && al_start_o)
	) else $error("run_o and al_start_o high together");

	// Auto-load request only released after the acknowledge, except on abort
	a_al_release: assert property (
		@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(al_start_o) && por_state_o == ST_AL_RELEASE |-> $past(sync_status_i.al_done)
	) else $error("al_start_o dropped before al_done");

	a_rst_in_wait: assert property (
		@(posedge CLK100KHZ) disable iff (!EOS)
		por_state_o == ST_WAIT_LOCK |-> sys_rst_o
	) else $error("sys_rst_o low while waiting for lock");

endmodule

// File: hw/adc_init_ctrl.sv
`timescale 1ns/1ps

module adc_init_ctrl import rst_mgr_pkg::*; (
	input  logic CLK100KHZ,
	input  logic EOS,
	input  logic adc_init_rst_i,
	input  logic adc_init_done_i,
	output logic adc_rst_o,
	output logic adc_init_o,
	output logic adc_rdy_o,
	output logic adc_tmo_o
);

	typedef enum logic [2:0] {PH_IDLE, PH_RST, PH_REQ, PH_REL, PH_RDY} adc_phase_e;

	adc_phase_e       phase;
	logic [TMR_W-1:0] cnt; // Reset pulse length, then init timeout
	logic             rst_q;
	logic             rst_fall;

	assign rst_fall = rst_q & ~adc_init_rst_i;

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			phase     <= PH_IDLE;
			cnt       <= '0;
			rst_q     <= 1'b1;
			adc_tmo_o <= 1'b0;
		end else begin
			rst_q <= adc_init_rst_i;
			if (adc_init_rst_i) begin
				phase     <= PH_IDLE;
				cnt       <= '0;
				adc_tmo_o <= 1'b0;
			end else begin
				case (phase)
					PH_IDLE: begin
						if (rst_fall) begin
							phase <= PH_RST;
							cnt   <= '0;
						end
					end
					PH_RST: begin
						if (cnt == TMR_W'(ADC_RST_LEN - 1)) begin
							phase <= PH_REQ;
							cnt   <= '0; // Reused as the timeout counter
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					PH_REQ: begin
						if (adc_init_done_i) begin
							phase <= PH_REL;
						end else if (cnt == TMR_W'(ADC_INIT_TMO - 1)) begin
							phase     <= PH_RDY; // Give up on the ADC
							adc_tmo_o <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					PH_REL: begin
						if (!adc_init_done_i) begin
							phase <= PH_RDY;
						end
					end
					default: begin
						phase <= phase;
					end
				endcase
			end
		end
	end

	assign adc_rst_o  = (phase == PH_RST);
	assign adc_init_o = (phase == PH_REQ);
	assign adc_rdy_o  = (phase == PH_RDY);

	a_init_hold: assert property (
		@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(adc_init_o) && !$past(adc_init_rst_i) |-> $past(adc_init_done_i) || adc_tmo_o
	) else $error("adc_init_o dropped without acknowledge or timeout");

endmodule

// File: hw/fifo_rst_gen.sv
`timescale 1ns/1ps

module fifo_rst_gen import rst_mgr_pkg::*; (
	input  logic CLK100KHZ,
	input  logic EOS,
	input  logic resync_i,
	output logic daq_fifo_rst_o
);

	logic             resync_q;
	logic             resync_rise;
	logic [TMR_W-1:0] cnt;

	assign resync_rise = resync_i & ~resync_q;

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			resync_q       <= 1'b0;
			cnt            <= '0;
			daq_fifo_rst_o <= 1'b0;
		end else begin
			resync_q <= resync_i;
			if (resync_rise) begin
				daq_fifo_rst_o <= 1'b1; // New resync restarts the pulse
				cnt            <= '0;
			end else if (daq_fifo_rst_o) begin
				if (cnt == TMR_W'(FIFO_RST_LEN - 1)) begin
					daq_fifo_rst_o <= 1'b0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// At most FIFO_RST_LEN cycles high after the last resync edge
	a_pulse_len: assert property (
		@(posedge CLK100KHZ) disable iff (!EOS)
		(daq_fifo_rst_o && !resync_rise) [*FIFO_RST_LEN] |=> !daq_fifo_rst_o
	) else $error("daq_fifo_rst_o pulse longer than FIFO_RST_LEN");

endmodule

// File: hw/tx_disable_gen.sv
`timescale 1ns/1ps

module tx_disable_gen import rst_mgr_pkg::*; (
	input  logic       CLK100KHZ,
	input  logic       EOS,
	input  logic       sys_rst_i,
	input  link_tdis_t op_rst_i,
	output link_tdis_t tdis_o
);

	logic [1:0] op_v;
	logic [1:0] tdis_v;

	assign op_v = op_rst_i; // Bit 1 is DAQ, bit 0 is trigger

	for (genvar i = 0; i < 2; i++) begin : g_link
		logic             req_q;
		logic             pulse;
		logic [TMR_W-1:0] cnt;

		always_ff @(posedge CLK100KHZ or negedge EOS) begin
			if (!EOS) begin
				req_q <= 1'b0;
				pulse <= 1'b0;
				cnt   <= '0;
			end else begin
				req_q <= op_v[i];
				if (sys_rst_i) begin
					pulse <= 1'b0;
					cnt   <= '0;
				end else if (op_v[i] && !req_q) begin
					pulse <= 1'b1;
					cnt   <= '0;
				end else if (pulse) begin
					if (cnt == TMR_W'(TDIS_PULSE_LEN - 1)) begin
						pulse <= 1'b0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			end
		end

		assign tdis_v[i] = sys_rst_i | pulse; // Laser off while in reset
	end

	assign tdis_o = link_tdis_t'(tdis_v);

endmodule

// File: hw/reset_manager.sv
`timescale 1ns/1ps

module reset_manager import rst_mgr_pkg::*; (
	input  logic       CLK100KHZ,
	input  logic       EOS,
	input  status_t    status_i,
	output logic       sys_rst_o,
	output logic       run_o,
	output logic       al_start_o,
	output logic       adc_rst_o,
	output logic       adc_init_o,
	output logic       adc_rdy_o,
	output logic       adc_tmo_o,
	output logic       daq_fifo_rst_o,
	output link_tdis_t tdis_o,
	output por_state_e por_state_o
);

	status_t    sync_status;
	logic       sys_rst;
	logic       adc_init_rst;
	logic       adc_rdy;
	link_tdis_t op_req;

	assign sys_rst_o  = sys_rst;
	assign adc_rdy_o  = adc_rdy;
	assign op_req.daq = sync_status.daq_op_rst;
	assign op_req.trg = sync_status.trg_op_rst;

	status_sync u_status_sync (
		.CLK100KHZ (CLK100KHZ),
		.EOS       (EOS),
		.status_i  (status_i),
		.status_o  (sync_status)
	);

	por_sequencer u_por_sequencer (
		.CLK100KHZ      (CLK100KHZ),
		.EOS            (EOS),
		.sync_status_i  (sync_status),
		.adc_rdy_i      (adc_rdy),
		.sys_rst_o      (sys_rst),
		.adc_init_rst_o (adc_init_rst),
		.al_start_o     (al_start_o),
		.run_o          (run_o),
		.por_state_o    (por_state_o)
	);

	adc_init_ctrl u_adc_init_ctrl (
		.CLK100KHZ       (CLK100KHZ),
		.EOS             (EOS),
		.adc_init_rst_i  (adc_init_rst),
		.adc_init_done_i (sync_status.adc_init_done),
		.adc_rst_o       (adc_rst_o),
		.adc_init_o      (adc_init_o),
		.adc_rdy_o       (adc_rdy),
		.adc_tmo_o       (adc_tmo_o)
	);

	fifo_rst_gen u_fifo_rst_gen (
		.CLK100KHZ      (CLK100KHZ),
		.EOS            (EOS),
		.resync_i       (sync_status.resync),
		.daq_fifo_rst_o (daq_fifo_rst_o)
	);

	tx_disable_gen u_tx_disable_gen (
		.CLK100KHZ (CLK100KHZ),
		.EOS       (EOS),
		.sys_rst_i (sys_rst),
		.op_rst_i  (op_req),
		.tdis_o    (tdis_o)
	);

endmodule

// File: sim/rst_checker.sv
`timescale 1ns/1ps

module rst_checker import rst_mgr_pkg::*; (
	input  logic       CLK100KHZ,
	input  logic       EOS,
	input  status_t    status_i,
	input  logic       expect_tmo_i,
	input  logic       sys_rst_i,
	input  logic       run_i,
	input  logic       al_start_i,
	input  logic       adc_rst_i,
	input  logic       adc_init_i,
	input  logic       adc_rdy_i,
	input  logic       adc_tmo_i,
	input  logic       daq_fifo_rst_i,
	input  link_tdis_t tdis_i,
	input  por_state_e por_state_i,
	output int         val_errs_o,
	output int         proto_errs_o
);

	int         val_errs = 0;
	int         proto_errs = 0;
	status_t    s_d1;
	status_t    s_d2;
	status_t    sync_q;    // Model of the synchroniser output
	status_t    sync_prev;
	por_state_e exp_state;
	por_state_e prev_state;
	int         dwell;
	int         adc_left;
	int         fifo_left;
	int         daq_left;
	int         trg_left;
	logic       exp_sys;
	logic       prev_sys;
	logic       al_prev;
	logic       init_prev;
	logic       rdy_prev;

	assign val_errs_o   = val_errs;
	assign proto_errs_o = proto_errs;

	// Expected next sequencer state
	function automatic por_state_e ref_next(por_state_e st, status_t s, logic rdy, int cycles);
		if (st != ST_WAIT_LOCK && (s.restart || !s.clk_lock)) begin
			return ST_WAIT_LOCK;
		end
		case (st)
			ST_WAIT_LOCK:
				return (s.clk_lock && !s.restart) ? ST_STRT_DLY : ST_WAIT_LOCK;
			ST_STRT_DLY:
				return (cycles >= STRT_DLY) ? ST_ADC_INIT : ST_STRT_DLY;
			ST_ADC_INIT:
				return rdy ? ST_AUTOLOAD : ST_ADC_INIT;
			ST_AUTOLOAD:
				return s.al_done ? ST_AL_RELEASE : ST_AUTOLOAD;
			ST_AL_RELEASE:
				return s.al_done ? ST_AL_RELEASE : ST_RUN;
			ST_RUN:
				return ST_RUN;
			default:
				return ST_WAIT_LOCK;
		endcase
	endfunction

	// Cycles left in a fixed length pulse
	function automatic int pulse_next(int left, logic trig, logic clr, int len);
		if (clr) begin
			return 0;
		end
		if (trig) begin
			return len;
		end
		return (left > 0) ? left - 1 : 0;
	endfunction

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
			val_errs++;
		end
	endtask

	task automatic proto_fail(input string what);
		$display("At %0t the %s", $time, what);
		proto_errs++;
	endtask

	always @(negedge CLK100KHZ) begin
		if (!EOS) begin
			check_val("sys_rst_o", sys_rst_i, 1'b1);
			check_val("run_o", run_i, 1'b0);
			check_val("al_start_o", al_start_i, 1'b0);
			check_val("adc_init_o", adc_init_i, 1'b0);
			check_val("adc_rdy_o", adc_rdy_i, 1'b0);
			check_val("daq_fifo_rst_o", daq_fifo_rst_i, 1'b0);
			check_val("tdis_o", tdis_i, 2'b11);
			check_val("por_state_o", por_state_i, ST_WAIT_LOCK);
			s_d1       = '0;
			s_d2       = '0;
			sync_prev  = '0;
			exp_state  = ST_WAIT_LOCK;
			prev_state = ST_WAIT_LOCK;
			dwell      = 0;
			adc_left   = 0;
			fifo_left  = 0;
			daq_left   = 0;
			trg_left   = 0;
			prev_sys   = 1'b1;
			al_prev    = 1'b0;
			init_prev  = 1'b0;
			rdy_prev   = 1'b0;
		end else begin
			sync_q  = s_d2;
			exp_sys = (exp_state == ST_WAIT_LOCK) || (exp_state == ST_STRT_DLY);
			check_val("por_state_o", por_state_i, exp_state);
			check_val("sys_rst_o", sys_rst_i, exp_sys);
			check_val("run_o", run_i, exp_state == ST_RUN);
			check_val("al_start_o", al_start_i, exp_state == ST_AUTOLOAD);
			check_val("adc_rst_o", adc_rst_i, adc_left > 0);
			check_val("daq_fifo_rst_o", daq_fifo_rst_i, fifo_left > 0);
			check_val("tdis_o", tdis_i, {exp_sys | (daq_left > 0), exp_sys | (trg_left > 0)});
			if (!expect_tmo_i) begin
				check_val("adc_tmo_o", adc_tmo_i, 1'b0);
			end
			if (al_start_i && !al_prev && sync_q.al_done)
				proto_fail("auto-load request rose while done was still high");
			if (!al_start_i && al_prev && !sync_prev.al_done && exp_state != ST_WAIT_LOCK)
				proto_fail("auto-load request fell before done");
			if (adc_init_i && !init_prev && sync_q.adc_init_done)
				proto_fail("ADC init request rose while done was still high");
			if (!adc_init_i && init_prev && !sync_prev.adc_init_done && !adc_tmo_i && !exp_sys)
				proto_fail("ADC init request fell without done or timeout");
			if (adc_rdy_i && !rdy_prev) begin
				check_val("adc_tmo_o", adc_tmo_i, expect_tmo_i);
				if (sync_prev.adc_init_done)
					proto_fail("ADC ready rose before init done fell");
			end
			adc_left  = pulse_next(adc_left, prev_sys && !exp_sys, exp_sys, ADC_RST_LEN);
			fifo_left = pulse_next(fifo_left, sync_q.resync && !sync_prev.resync, 1'b0,
				FIFO_RST_LEN);
			daq_left  = pulse_next(daq_left, sync_q.daq_op_rst && !sync_prev.daq_op_rst,
				exp_sys, TDIS_PULSE_LEN);
			trg_left  = pulse_next(trg_left, sync_q.trg_op_rst && !sync_prev.trg_op_rst,
				exp_sys, TDIS_PULSE_LEN);
			dwell      = (exp_state == prev_state) ? dwell + 1 : 1;
			prev_state = exp_state;
			exp_state  = ref_next(exp_state, sync_q, adc_rdy_i, dwell);
			s_d2       = s_d1; // Two cycle input delay
			s_d1       = status_i;
			sync_prev  = sync_q;
			prev_sys   = exp_sys;
			al_prev    = al_start_i;
			init_prev  = adc_init_i;
			rdy_prev   = adc_rdy_i;
		end
	end

endmodule

// File: sim/tb_reset_manager.sv
`timescale 1ns/1ps

module tb_reset_manager import rst_mgr_pkg::*; ();

	localparam int CLK_PERIOD   = 8;
	localparam int NUM_STARTUPS = 4;
	localparam int STARTUP_MAX  = STRT_DLY + ADC_RST_LEN + ADC_INIT_TMO + 2 * 16 + 16;
	localparam int PULSE_MAX    = FIFO_RST_LEN + 2 * TDIS_PULSE_LEN + 3 * 8;
	localparam int WD_CYCLES    = 2 * (NUM_STARTUPS * STARTUP_MAX + PULSE_MAX);

	logic       CLK100KHZ = 1'b0;
	logic       EOS;
	status_t    status_i;
	logic       sys_rst_o;
	logic       run_o;
	logic       al_start_o;
	logic       adc_rst_o;
	logic       adc_init_o;
	logic       adc_rdy_o;
	logic       adc_tmo_o;
	logic       daq_fifo_rst_o;
	link_tdis_t tdis_o;
	por_state_e por_state_o;
	logic       adc_quiet;  // ADC ignores init requests
	logic       expect_tmo;
	int         val_errs;
	int         proto_errs;
	int         wait_errs = 0;
	integer     seed = 32'h3935_5ff2;

	always #(CLK_PERIOD / 2) CLK100KHZ = ~CLK100KHZ;

	reset_manager u_dut (
		.CLK100KHZ      (CLK100KHZ),
		.EOS            (EOS),
		.status_i       (status_i),
		.sys_rst_o      (sys_rst_o),
		.run_o          (run_o),
		.al_start_o     (al_start_o),
		.adc_rst_o      (adc_rst_o),
		.adc_init_o     (adc_init_o),
		.adc_rdy_o      (adc_rdy_o),
		.adc_tmo_o      (adc_tmo_o),
		.daq_fifo_rst_o (daq_fifo_rst_o),
		.tdis_o         (tdis_o),
		.por_state_o    (por_state_o)
	);

	rst_checker u_checker (
		.CLK100KHZ      (CLK100KHZ),
		.EOS            (EOS),
		.status_i       (status_i),
		.expect_tmo_i   (expect_tmo),
		.sys_rst_i      (sys_rst_o),
		.run_i          (run_o),
		.al_start_i     (al_start_o),
		.adc_rst_i      (adc_rst_o),
		.adc_init_i     (adc_init_o),
		.adc_rdy_i      (adc_rdy_o),
		.adc_tmo_i      (adc_tmo_o),
		.daq_fifo_rst_i (daq_fifo_rst_o),
		.tdis_i         (tdis_o),
		.por_state_i    (por_state_o),
		.val_errs_o     (val_errs),
		.proto_errs_o   (proto_errs)
	);

	function automatic int pick_delay();
		return $unsigned($random(seed)) % 16;
	endfunction

	task automatic skip_cycles(input int n);
		repeat (n) @(posedge CLK100KHZ);
	endtask

	task automatic wait_state(input por_state_e target, input string what);
		int n;
		n = 0;
		do begin
			@(negedge CLK100KHZ);
			n++;
		end while (por_state_o != target && n < STARTUP_MAX);
		if (por_state_o != target) begin
			$display("%s timed out waiting for state %0d", what, target);
			wait_errs++;
		end
	endtask

	// ADC init responder
	always begin
		@(negedge CLK100KHZ);
		if (adc_init_o && !adc_quiet) begin
			skip_cycles(pick_delay());
			@(posedge CLK100KHZ);
			status_i.adc_init_done <= 1'b1;
			do begin
				@(negedge CLK100KHZ);
			end while (adc_init_o);
			skip_cycles(pick_delay());
			@(posedge CLK100KHZ);
			status_i.adc_init_done <= 1'b0;
		end
	end

	// Auto-load engine
	always begin
		@(negedge CLK100KHZ);
		if (al_start_o) begin
			skip_cycles(pick_delay());
			@(posedge CLK100KHZ);
			status_i.al_done <= 1'b1;
			do begin
				@(negedge CLK100KHZ);
			end while (al_start_o);
			skip_cycles(pick_delay());
			@(posedge CLK100KHZ);
			status_i.al_done <= 1'b0;
		end
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles and the run did not finish", WD_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		EOS        = 1'b0;
		status_i   = '0;
		adc_quiet  = 1'b0;
		expect_tmo = 1'b0;
		skip_cycles(4);
		EOS <= 1'b1;
		@(posedge CLK100KHZ);
		status_i.clk_lock <= 1'b1;
		wait_state(ST_RUN, "Normal startup");
		@(posedge CLK100KHZ);
		status_i.resync <= 1'b1;
		@(posedge CLK100KHZ);
		status_i.resync <= 1'b0;
		skip_cycles(FIFO_RST_LEN + 6);
		status_i.daq_op_rst <= 1'b1;
		@(posedge CLK100KHZ);
		status_i.daq_op_rst <= 1'b0;
		skip_cycles(TDIS_PULSE_LEN + 6);
		status_i.trg_op_rst <= 1'b1;
		@(posedge CLK100KHZ);
		status_i.trg_op_rst <= 1'b0;
		skip_cycles(TDIS_PULSE_LEN + 6);
		status_i.restart <= 1'b1; // Restart from RUN
		wait_state(ST_WAIT_LOCK, "Restart");
		@(posedge CLK100KHZ);
		status_i.restart <= 1'b0;
		wait_state(ST_RUN, "Startup after restart");
		@(posedge CLK100KHZ);
		status_i.clk_lock <= 1'b0;
		wait_state(ST_WAIT_LOCK, "Lock loss");
		@(posedge CLK100KHZ);
		status_i.clk_lock <= 1'b1;
		wait_state(ST_RUN, "Startup after lock loss");
		@(posedge CLK100KHZ);
		adc_quiet        <= 1'b1; // ADC timeout run
		expect_tmo       <= 1'b1;
		status_i.restart <= 1'b1;
		wait_state(ST_WAIT_LOCK, "Restart before ADC timeout");
		@(posedge CLK100KHZ);
		status_i.restart <= 1'b0;
		wait_state(ST_RUN, "Startup with silent ADC");
		skip_cycles(4);
		$display("Checks done: %0d value errors, %0d protocol errors, %0d wait timeouts",
			val_errs, proto_errs, wait_errs);
		if (val_errs + proto_errs + wait_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: reset_manager.f
hw/rst_mgr_pkg.sv
hw/status_sync.sv
hw/por_sequencer.sv
hw/adc_init_ctrl.sv
hw/fifo_rst_gen.sv
hw/tx_disable_gen.sv
hw/reset_manager.sv
sim/rst_checker.sv
sim/tb_reset_manager.sv
